// File: cache.f
rtl/cache_geom_pkg.sv
rtl/cache_bus_pkg.sv
rtl/cache_ways.sv
rtl/plru_tree.sv
rtl/cache_ctrl.sv
rtl/cache.sv
dv/cache_checker.sv
dv/dfp_mem_model.sv
dv/cache_scoreboard.sv
dv/cache_tb.sv

// File: Bender.yml
package:
  name: cache

sources:
  - files:
      - rtl/cache_geom_pkg.sv
      - rtl/cache_bus_pkg.sv
      - rtl/cache_ways.sv
      - rtl/plru_tree.sv
      - rtl/cache_ctrl.sv
      - rtl/cache.sv
  - target: test
    files:
      - dv/cache_checker.sv
      - dv/dfp_mem_model.sv
      - dv/cache_scoreboard.sv
      - dv/cache_tb.sv

// File: dv/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    localparam int directed_requests = 14;
    localparam int random_requests   = 400;
    // worst case is a dirty miss with two memory trips of about four cycles each
    localparam int cycles_per_request = 2 * 4 + 4;
    localparam int cycle_limit =
        (directed_requests + random_requests) * cycles_per_request + 1000;

    logic        clk;
    logic        rst;
    ufp_req_t    ufp_req;
    logic [31:0] ufp_rdata;
    logic        ufp_resp;
    dfp_req_t    dfp_req;
    line_t       dfp_rdata;
    logic        dfp_resp;
    logic [31:0] lfsr;
    int unsigned cycles;
    int unsigned sb_errors;

    cache uut (
        .clk       (clk),
        .rst       (rst),
        .ufp_req   (ufp_req),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_req   (dfp_req),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    dfp_mem_model u_mem (
        .clk       (clk),
        .rst       (rst),
        .dfp_req   (dfp_req),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    cache_scoreboard u_sb (
        .clk       (clk),
        .rst       (rst),
        .ufp_req   (ufp_req),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_req   (dfp_req),
        .dfp_resp  (dfp_resp),
        .errors    (sb_errors)
    );

    bind cache cache_checker u_checker (
        .clk      (clk),
        .rst      (rst),
        .ufp_req  (ufp_req),
        .ufp_resp (ufp_resp),
        .dfp_req  (dfp_req)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [31:0] make_addr(input tag_t tag, input set_idx_t set,
                                              input logic [2:0] word);
        cache_addr_u a;
        a.f.tag    = tag;
        a.f.set    = set;
        a.f.offset = {word, 2'b00};
        return a.word;
    endfunction

    // request is held until the edge that samples ufp_resp
    task automatic send_request(input logic [31:0] req_addr, input logic [3:0] req_rmask,
                                input logic [3:0] req_wmask, input logic [31:0] req_wdata);
        ufp_req <= '{addr: req_addr, rmask: req_rmask, wmask: req_wmask, wdata: req_wdata};
        do begin
            @(posedge clk);
        end while (!ufp_resp);
    endtask

    task automatic idle_cycles(input int n);
        ufp_req <= '0;
        repeat (n) @(posedge clk);
    endtask

    initial begin
        logic [31:0] bits;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mask;
        tag_t        tag;
        set_idx_t    set;
        logic [2:0]  word;

        rst     = 1'b1;
        ufp_req = '0;
        lfsr    = 32'h8af8_62b1;
        cycles  = 0;
        u_sb.start_test("idle_after_reset");
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        idle_cycles(10);

        u_sb.start_test("read_miss_then_hit");
        addr = make_addr(23'h00_1234, 4'd3, 3'd5);
        send_request(addr, 4'hf, 4'h0, '0);
        send_request(addr, 4'hf, 4'h0, '0);
        idle_cycles(1);

        u_sb.start_test("partial_write_hit");
        send_request(addr, 4'h0, 4'b0110, 32'hdead_beef);
        send_request(addr, 4'b0001, 4'h0, '0);
        idle_cycles(1);

        // five tags in one set force one eviction of a dirty line
        u_sb.start_test("set_eviction");
        for (int t = 0; t < 5; t++) begin
            addr = make_addr(23'h00_0040 + tag_t'(t), 4'd9, 3'(t));
            send_request(addr, 4'h0, 4'b1011, 32'hc0de_0000 + 32'(t));
        end
        for (int t = 0; t < 5; t++) begin
            addr = make_addr(23'h00_0040 + tag_t'(t), 4'd9, 3'(t));
            send_request(addr, 4'hf, 4'h0, '0);
        end
        idle_cycles(1);

        u_sb.start_test("random_traffic");
        for (int i = 0; i < random_requests; i++) begin
            take_bits(3, bits);
            tag = {17'h0_0021, bits[2:0], 3'b011};
            take_bits(2, bits);
            set = {2'b01, bits[1:0]};
            take_bits(3, bits);
            word = bits[2:0];
            addr = make_addr(tag, set, word);
            take_bits(1, bits);
            if (bits[0]) begin
                take_bits(4, bits);
                mask = (bits[3:0] == 4'h0) ? 4'b0001 : bits[3:0];
                take_bits(32, bits);
                wdata = bits;
                send_request(addr, 4'h0, mask, wdata);
            end else begin
                take_bits(4, bits);
                mask = (bits[3:0] == 4'h0) ? 4'hf : bits[3:0];
                send_request(addr, mask, 4'h0, '0);
            end
        end
        idle_cycles(2);

        u_sb.final_sweep();
        $display("errors: scoreboard %0d, assertions %0d", sb_errors,
                 uut.u_checker.violations);
        if (sb_errors == 0 && uut.u_checker.violations == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/cache_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module cache_scoreboard (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_bus_pkg::ufp_req_t ufp_req,
    input  logic [31:0]             ufp_rdata,
    input  logic                    ufp_resp,
    input  cache_bus_pkg::dfp_req_t dfp_req,
    input  logic                    dfp_resp,
    output int unsigned             errors
);

    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    logic [7:0]           shadow        [logic [31:0]];
    bit                   touched_lines [logic [31:0]];
    tag_t                 model_tag     [set_count][way_count];
    logic [way_count-1:0] model_valid   [set_count];
    logic [way_count-1:0] model_dirty   [set_count];
    plru_t                model_plru    [set_count];
    logic [31:0]          wb_seen       [$];
    int unsigned          req_cycles;
    string                test_name = "none";

    initial begin
        errors     = 0;
        req_cycles = 0;
    end

    task automatic start_test(input string name);
        test_name = name;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what,
                 expected, actual);
        errors++;
    endtask

    function automatic logic [31:0] init_word(input logic [31:0] addr);
        logic [31:0] wa;
        wa = {addr[31:2], 2'b00};
        return (wa * 32'h9e37_79b1) ^ {wa[15:0], wa[31:16]};
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [31:0] addr);
        logic [31:0] w;
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        w = init_word(addr);
        return w[addr[1:0]*8 +: 8];
    endfunction

    // reference for the word that a read of addr returns
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] base;
        logic [31:0] result;
        base = {addr[31:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            result[b*8 +: 8] = shadow_byte(base + 32'(b));
        end
        return result;
    endfunction

    // bit 2 picks the half and 0 selects ways 2-3
    function automatic way_idx_t plru_victim(input plru_t bits);
        if (bits[2]) begin
            return bits[1] ? 2'd0 : 2'd1;
        end
        return bits[0] ? 2'd2 : 2'd3;
    endfunction

    function automatic plru_t plru_point_away(input plru_t bits, input way_idx_t way);
        plru_t r;
        r    = bits;
        r[2] = way[1];
        if (way[1]) begin
            r[0] = way[0];
        end else begin
            r[1] = way[0];
        end
        return r;
    endfunction

    task automatic check_response();
        cache_addr_u a;
        cache_addr_u wb;
        set_idx_t    s;
        way_idx_t    way;
        logic        hit;
        logic [31:0] exp;
        a.word = ufp_req.addr;
        s      = a.f.set;
        hit    = 1'b0;
        way    = '0;
        for (int w = 0; w < way_count; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == a.f.tag) begin
                hit = 1'b1;
                way = way_idx_t'(w);
            end
        end
        if (hit) begin
            if (req_cycles != 1) begin
                report_mismatch("hit latency", 32'd1, req_cycles);
            end
        end else begin
            way = plru_victim(model_plru[s]);
            if (model_valid[s][way] && model_dirty[s][way]) begin
                wb.f.tag    = model_tag[s][way];
                wb.f.set    = s;
                wb.f.offset = '0;
                if (wb_seen.size() == 0) begin
                    $display("missing writeback of dirty line %h in test %s", wb.word,
                             test_name);
                    errors++;
                end else begin
                    if (wb_seen[0] !== wb.word) begin
                        report_mismatch("writeback address", wb.word, wb_seen[0]);
                    end
                    void'(wb_seen.pop_front());
                end
            end
            model_tag[s][way]   = a.f.tag;
            model_valid[s][way] = 1'b1;
            model_dirty[s][way] = 1'b0;
        end
        if (wb_seen.size() != 0) begin
            $display("unexpected writeback of line %h in test %s", wb_seen[0], test_name);
            errors++;
            wb_seen.delete();
        end
        model_plru[s] = plru_point_away(model_plru[s], way);
        if (|ufp_req.wmask) begin
            for (int b = 0; b < 4; b++) begin
                if (ufp_req.wmask[b]) begin
                    shadow[{a.word[31:2], 2'(b)}] = ufp_req.wdata[b*8 +: 8];
                end
            end
            model_dirty[s][way]                 = 1'b1;
            touched_lines[{a.word[31:5], 5'b0}] = 1'b1;
        end
        if (|ufp_req.rmask) begin
            exp = expected_word(a.word);
            if (ufp_rdata !== exp) begin
                report_mismatch("read data", exp, ufp_rdata);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < set_count; s++) begin
                model_valid[s] = '0;
                model_dirty[s] = '0;
                model_plru[s]  = '0;
            end
            req_cycles = 0;
            wb_seen.delete();
        end else begin
            if (dfp_req.write && dfp_resp) begin
                wb_seen.push_back(dfp_req.addr);
            end
            if (!ufp_resp && ufp_rdata !== 32'h0) begin
                report_mismatch("rdata without response", 32'h0, ufp_rdata);
            end
            if (!(|ufp_req.rmask || |ufp_req.wmask)) begin
                if (ufp_resp || dfp_req.read || dfp_req.write) begin
                    report_mismatch("quiet when idle", 32'h0,
                                    {29'h0, ufp_resp, dfp_req.read, dfp_req.write});
                end
            end else if (ufp_resp) begin
                check_response();
                req_cycles = 0;
            end else begin
                req_cycles++;
            end
        end
    end

    // written lines that the cache no longer holds must be in memory
    task automatic final_sweep();
        cache_addr_u la;
        line_t       mem_line;
        logic        held;
        logic [31:0] exp;
        foreach (touched_lines[key]) begin
            la.word = key;
            held    = 1'b0;
            for (int w = 0; w < way_count; w++) begin
                if (model_valid[la.f.set][w] && model_tag[la.f.set][w] == la.f.tag) begin
                    held = 1'b1;
                end
            end
            if (!held) begin
                mem_line = cache_tb.u_mem.line_at(la.word);
                for (int i = 0; i < line_bits / 32; i++) begin
                    exp = expected_word(la.word + 32'(i * 4));
                    if (mem_line[i*32 +: 32] !== exp) begin
                        report_mismatch("memory sweep", exp, mem_line[i*32 +: 32]);
                    end
                end
            end
        end
    endtask

endmodule

`default_nettype wire

// File: dv/dfp_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dfp_mem_model (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_bus_pkg::dfp_req_t dfp_req,
    output cache_geom_pkg::line_t   dfp_rdata,
    output logic                    dfp_resp
);

    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    localparam int resp_delay = 3;

    line_t       lines [logic [31:0]];
    int unsigned wait_count;

    function automatic logic [31:0] init_word(input logic [31:0] addr);
        logic [31:0] wa;
        wa = {addr[31:2], 2'b00};
        return (wa * 32'h9e37_79b1) ^ {wa[15:0], wa[31:16]};
    endfunction

    // lines never written still hold their initial pattern
    function automatic line_t line_at(input logic [31:0] addr);
        cache_addr_u la;
        line_t       result;
        la.word     = addr;
        la.f.offset = '0;
        if (lines.exists(la.word)) begin
            return lines[la.word];
        end
        for (int i = 0; i < line_bits / 32; i++) begin
            result[i*32 +: 32] = init_word(la.word + 32'(i * 4));
        end
        return result;
    endfunction

    initial begin
        dfp_rdata  = '0;
        dfp_resp   = 1'b0;
        wait_count = 0;
    end

    always @(posedge clk) begin
        dfp_resp <= 1'b0;
        if (rst) begin
            wait_count <= 0;
        end else if ((dfp_req.read || dfp_req.write) && !dfp_resp) begin
            if (wait_count == resp_delay - 1) begin
                wait_count <= 0;
                dfp_resp   <= 1'b1;
                if (dfp_req.write) begin
                    lines[{dfp_req.addr[31:5], 5'b0}] = dfp_req.wdata;
                end else begin
                    dfp_rdata <= line_at(dfp_req.addr);
                end
            end else begin
                wait_count <= wait_count + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/cache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cache_checker (
    input logic                    clk,
    input logic                    rst,
    input cache_bus_pkg::ufp_req_t ufp_req,
    input logic                    ufp_resp,
    input cache_bus_pkg::dfp_req_t dfp_req
);

    import cache_bus_pkg::*;

    int unsigned violations = 0;

    resp_single_cycle: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |=> !ufp_resp)
        else begin
            $error("ufp_resp held for two cycles");
            violations++;
        end

    dfp_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(dfp_req.read && dfp_req.write))
        else begin
            $error("dfp read and write high together");
            violations++;
        end

    dfp_line_aligned: assert property (@(posedge clk) disable iff (rst)
        (dfp_req.read || dfp_req.write) |-> dfp_req.addr[4:0] == 5'b0)
        else begin
            $error("dfp address not line aligned");
            violations++;
        end

    resp_needs_request: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |-> (|ufp_req.rmask || |ufp_req.wmask))
        else begin
            $error("ufp_resp without a request");
            violations++;
        end

endmodule

`default_nettype wire

// File: rtl/cache.sv
`timescale 1ns/1ps
`default_nettype none

module cache (
    input  logic                     clk,
    input  logic                     rst,
    input  cache_bus_pkg::ufp_req_t  ufp_req,
    output logic [31:0]              ufp_rdata,
    output logic                     ufp_resp,
    output cache_bus_pkg::dfp_req_t  dfp_req,
    input  cache_geom_pkg::line_t    dfp_rdata,
    input  logic                     dfp_resp
);

    import cache_geom_pkg::*;

    set_idx_t                     set_idx;
    logic                         rd_en;
    logic [way_count-1:0]         tag_we;
    logic [way_count-1:0]         data_we;
    logic [31:0]                  data_be;
    line_t                        wr_line;
    tag_t                         wr_tag;
    logic [way_count-1:0]         valid_we;
    logic [way_count-1:0]         dirty_we;
    logic                         dirty_in;
    tag_t  [way_count-1:0]        rd_tag;
    line_t [way_count-1:0]        rd_line;
    logic [way_count-1:0]         rd_valid;
    logic [way_count-1:0]         rd_dirty;
    logic                         touch_en;
    way_idx_t                     touch_way;
    way_idx_t                     victim;

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .ufp_req   (ufp_req),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_req   (dfp_req),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp),
        .set_idx   (set_idx),
        .rd_en     (rd_en),
        .tag_we    (tag_we),
        .data_we   (data_we),
        .data_be   (data_be),
        .wr_line   (wr_line),
        .wr_tag    (wr_tag),
        .valid_we  (valid_we),
        .dirty_we  (dirty_we),
        .dirty_in  (dirty_in),
        .rd_tag    (rd_tag),
        .rd_line   (rd_line),
        .rd_valid  (rd_valid),
        .rd_dirty  (rd_dirty),
        .touch_en  (touch_en),
        .touch_way (touch_way),
        .victim    (victim)
    );

    cache_ways u_ways (
        .clk      (clk),
        .rst      (rst),
        .set_idx  (set_idx),
        .rd_en    (rd_en),
        .tag_we   (tag_we),
        .data_we  (data_we),
        .data_be  (data_be),
        .wr_line  (wr_line),
        .wr_tag   (wr_tag),
        .valid_we (valid_we),
        .dirty_we (dirty_we),
        .dirty_in (dirty_in),
        .rd_tag   (rd_tag),
        .rd_line  (rd_line),
        .rd_valid (rd_valid),
        .rd_dirty (rd_dirty)
    );

    plru_tree u_plru (
        .clk       (clk),
        .rst       (rst),
        .set_idx   (set_idx),
        .touch_en  (touch_en),
        .touch_way (touch_way),
        .victim    (victim)
    );

endmodule

`default_nettype wire

// File: rtl/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  cache_bus_pkg::ufp_req_t                                ufp_req,
    output logic [31:0]                                            ufp_rdata,
    output logic                                                   ufp_resp,
    output cache_bus_pkg::dfp_req_t                                dfp_req,
    input  cache_geom_pkg::line_t                                  dfp_rdata,
    input  logic                                                   dfp_resp,
    output cache_geom_pkg::set_idx_t                               set_idx,
    output logic                                                   rd_en,
    output logic [cache_geom_pkg::way_count-1:0]                   tag_we,
    output logic [cache_geom_pkg::way_count-1:0]                   data_we,
    output logic [31:0]                                            data_be,
    output cache_geom_pkg::line_t                                  wr_line,
    output cache_geom_pkg::tag_t                                   wr_tag,
    output logic [cache_geom_pkg::way_count-1:0]                   valid_we,
    output logic [cache_geom_pkg::way_count-1:0]                   dirty_we,
    output logic                                                   dirty_in,
    input  cache_geom_pkg::tag_t  [cache_geom_pkg::way_count-1:0]  rd_tag,
    input  cache_geom_pkg::line_t [cache_geom_pkg::way_count-1:0]  rd_line,
    input  logic [cache_geom_pkg::way_count-1:0]                   rd_valid,
    input  logic [cache_geom_pkg::way_count-1:0]                   rd_dirty,
    output logic                                                   touch_en,
    output cache_geom_pkg::way_idx_t                               touch_way,
    input  cache_geom_pkg::way_idx_t                               victim
);

    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_allocate,
        st_fill,
        st_respond
    } state_t;

    state_t      state;
    state_t      state_next;
    ufp_req_t    req_q;
    line_t       line_buf;
    line_t       merged_line;
    cache_addr_u live_addr;
    cache_addr_u req_addr;
    cache_addr_u mem_addr;
    logic [2:0]  word_idx;
    logic [31:0] be_word;
    logic        req_live;
    logic        req_rd;
    logic        req_wr;
    logic        hit;
    way_idx_t    hit_way;
    logic        victim_dirty;

    always_comb begin
        live_addr.word = ufp_req.addr;
        req_addr.word  = req_q.addr;
    end

    assign req_live = (|ufp_req.rmask) || (|ufp_req.wmask);
    assign req_rd   = |req_q.rmask;
    assign req_wr   = |req_q.wmask;
    assign word_idx = req_addr.f.offset[4:2];
    assign be_word  = 32'(req_q.wmask) << {word_idx, 2'b00};

    // arrays are addressed by the live request only while idle
    assign set_idx = (state == st_idle) ? live_addr.f.set : req_addr.f.set;
    assign rd_en   = (state == st_idle) && req_live;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req_live) begin
            req_q <= ufp_req;
        end
        if (state == st_allocate && dfp_resp) begin
            line_buf <= dfp_rdata;
        end
    end

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < way_count; w++) begin
            if (rd_valid[w] && rd_tag[w] == req_addr.f.tag) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign victim_dirty = rd_valid[victim] && rd_dirty[victim];

    // write bytes over the fetched line; on a hit only the enabled bytes land
    always_comb begin
        for (int b = 0; b < line_bits / 8; b++) begin
            merged_line[b*8 +: 8] = be_word[b] ? req_q.wdata[(b % 4)*8 +: 8]
                                               : line_buf[b*8 +: 8];
        end
    end

    assign wr_line = merged_line;
    assign wr_tag  = req_addr.f.tag;

    // writeback goes to the victim's own line, allocate to the request's line
    always_comb begin
        mem_addr.f.tag    = (state == st_writeback) ? rd_tag[victim] : req_addr.f.tag;
        mem_addr.f.set    = req_addr.f.set;
        mem_addr.f.offset = '0;
    end

    always_comb begin
        state_next    = state;
        ufp_resp      = 1'b0;
        dfp_req.addr  = mem_addr.word;
        dfp_req.read  = 1'b0;
        dfp_req.write = 1'b0;
        dfp_req.wdata = rd_line[victim];
        tag_we        = '0;
        data_we       = '0;
        data_be       = be_word;
        valid_we      = '0;
        dirty_we      = '0;
        dirty_in      = 1'b0;
        touch_en      = 1'b0;
        touch_way     = hit_way;

        case (state)
            st_idle: begin
                if (req_live) begin
                    state_next = st_compare;
                end
            end
            st_compare: begin
                if (hit) begin
                    ufp_resp   = 1'b1;
                    touch_en   = 1'b1;
                    state_next = st_idle;
                    if (req_wr) begin
                        data_we[hit_way]  = 1'b1;
                        dirty_we[hit_way] = 1'b1;
                        dirty_in          = 1'b1;
                    end
                end else if (victim_dirty) begin
                    state_next = st_writeback;
                end else begin
                    state_next = st_allocate;
                end
            end
            st_writeback: begin
                dfp_req.write = 1'b1;
                if (dfp_resp) begin
                    state_next = st_allocate;
                end
            end
            st_allocate: begin
                dfp_req.read = 1'b1;
                if (dfp_resp) begin
                    state_next = st_fill;
                end
            end
            st_fill: begin
                tag_we[victim]   = 1'b1;
                data_we[victim]  = 1'b1;
                valid_we[victim] = 1'b1;
                dirty_we[victim] = 1'b1;
                dirty_in         = req_wr;
                data_be          = '1;
                touch_en         = 1'b1;
                touch_way        = victim;
                state_next       = st_respond;
            end
            st_respond: begin
                ufp_resp   = 1'b1;
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_comb begin
        ufp_rdata = '0;
        if (ufp_resp && req_rd) begin
            if (state == st_respond) begin
                ufp_rdata = line_buf[word_idx*32 +: 32];
            end else begin
                ufp_rdata = rd_line[hit_way][word_idx*32 +: 32];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/plru_tree.sv
`timescale 1ns/1ps
`default_nettype none

module plru_tree (
    input  logic                     clk,
    input  logic                     rst,
    input  cache_geom_pkg::set_idx_t set_idx,
    input  logic                     touch_en,
    input  cache_geom_pkg::way_idx_t touch_way,
    output cache_geom_pkg::way_idx_t victim
);

    import cache_geom_pkg::*;

    plru_t plru_q [set_count];
    plru_t cur;
    plru_t touched;

    assign cur = plru_q[set_idx];

    always_comb begin
        if (cur[2]) begin
            victim = cur[1] ? 2'd0 : 2'd1;
        end else begin
            victim = cur[0] ? 2'd2 : 2'd3;
        end
    end

    // point both levels of the tree away from the touched way
    always_comb begin
        touched = cur;
        case (touch_way)
            2'd0: begin
                touched[2] = 1'b0;
                touched[1] = 1'b0;
            end
            2'd1: begin
                touched[2] = 1'b0;
                touched[1] = 1'b1;
            end
            2'd2: begin
                touched[2] = 1'b1;
                touched[0] = 1'b0;
            end
            default: begin
                touched[2] = 1'b1;
                touched[0] = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < set_count; s++) begin
                plru_q[s] <= '0;
            end
        end else if (touch_en) begin
            plru_q[set_idx] <= touched;
        end
    end

endmodule

`default_nettype wire

// File: rtl/cache_ways.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ways (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  cache_geom_pkg::set_idx_t                               set_idx,
    input  logic                                                   rd_en,
    input  logic [cache_geom_pkg::way_count-1:0]                   tag_we,
    input  logic [cache_geom_pkg::way_count-1:0]                   data_we,
    input  logic [31:0]                                            data_be,
    input  cache_geom_pkg::line_t                                  wr_line,
    input  cache_geom_pkg::tag_t                                   wr_tag,
    input  logic [cache_geom_pkg::way_count-1:0]                   valid_we,
    input  logic [cache_geom_pkg::way_count-1:0]                   dirty_we,
    input  logic                                                   dirty_in,
    output cache_geom_pkg::tag_t  [cache_geom_pkg::way_count-1:0]  rd_tag,
    output cache_geom_pkg::line_t [cache_geom_pkg::way_count-1:0]  rd_line,
    output logic [cache_geom_pkg::way_count-1:0]                   rd_valid,
    output logic [cache_geom_pkg::way_count-1:0]                   rd_dirty
);

    import cache_geom_pkg::*;

    tag_t                 tag_mem  [set_count][way_count];
    line_t                data_mem [set_count][way_count];
    logic [way_count-1:0] valid_q  [set_count];
    logic [way_count-1:0] dirty_q  [set_count];

    // tag and line storage, line writes are byte enabled
    always_ff @(posedge clk) begin
        for (int w = 0; w < way_count; w++) begin
            if (tag_we[w]) begin
                tag_mem[set_idx][w] <= wr_tag;
            end
            for (int b = 0; b < line_bits / 8; b++) begin
                if (data_we[w] && data_be[b]) begin
                    data_mem[set_idx][w][b*8 +: 8] <= wr_line[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < set_count; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            for (int w = 0; w < way_count; w++) begin
                if (valid_we[w]) begin
                    valid_q[set_idx][w] <= 1'b1;
                end
                if (dirty_we[w]) begin
                    dirty_q[set_idx][w] <= dirty_in;
                end
            end
        end
    end

    // registered read, held until the next rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < way_count; w++) begin
                rd_tag[w]  <= tag_mem[set_idx][w];
                rd_line[w] <= data_mem[set_idx][w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= '0;
            rd_dirty <= '0;
        end else if (rd_en) begin
            rd_valid <= valid_q[set_idx];
            rd_dirty <= dirty_q[set_idx];
        end
    end

endmodule

`default_nettype wire

// File: rtl/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

    // requester side, held as levels until the response edge
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } ufp_req_t;

    // memory side, whole lines only
    typedef struct packed {
        logic [31:0]           addr;
        logic                  read;
        logic                  write;
        cache_geom_pkg::line_t wdata;
    } dfp_req_t;

endpackage

`default_nettype wire

// File: rtl/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    localparam int way_count   = 4;
    localparam int set_bits    = 4;
    localparam int tag_bits    = 23;
    localparam int offset_bits = 5;

    localparam int set_count = 1 << set_bits;
    localparam int line_bits = 8 << offset_bits;

    typedef logic [line_bits-1:0] line_t;
    typedef logic [1:0]           way_idx_t;
    typedef logic [set_bits-1:0]  set_idx_t;
    typedef logic [tag_bits-1:0]  tag_t;

    // bit 2 picks the half (0 -> ways 2-3), bit 1 picks in 0-1 (0 -> way 1),
    // bit 0 picks in 2-3 (0 -> way 3)
    typedef logic [2:0] plru_t;

    typedef struct packed {
        tag_t                   tag;
        set_idx_t               set;
        logic [offset_bits-1:0] offset;
    } addr_fields_t;

    // word index within a line is offset[4:2]
    typedef union packed {
        logic [31:0]  word;
        addr_fields_t f;
    } cache_addr_u;

endpackage

`default_nettype wire
